//--- common/tag_trace_rom.svh
`ifndef TAG_TRACE_ROM_SVH
`define TAG_TRACE_ROM_SVH

// Tag programming trace, read in address order
// Fields: op, '{masters, node, data_not_reset, len, payload}
// Unlisted addresses read as TR_DONE
localparam trace_entry_s TRACE_ROM [TRACE_ROM_DEPTH] = '{
  // Release output disable, both masters
  0: '{TR_SEND, '{2'b11, 4'd2, 1'b1, 4'd1, 8'h00}},
  // Master 1 only, some other node
  1: '{TR_SEND, '{2'b10, 4'd5, 1'b1, 4'd8, 8'hA5}},
  2: '{TR_WAIT, '{2'b00, 4'd0, 1'b0, 4'd0, 8'd20}},
  3: '{TR_SEND, '{2'b11, 4'd2, 1'b1, 4'd4, 8'h0B}},
  // Master 0 only
  4: '{TR_SEND, '{2'b01, 4'd2, 1'b1, 4'd8, 8'h3C}},
  5: '{TR_SEND, '{2'b11, 4'd7, 1'b1, 4'd6, 8'h2A}},
  6: '{TR_WAIT, '{2'b00, 4'd0, 1'b0, 4'd0, 8'd5}},
  // Client back to its reset value
  7: '{TR_SEND, '{2'b11, 4'd2, 1'b0, 4'd1, 8'h00}},
  8: '{TR_SEND, '{2'b11, 4'd2, 1'b1, 4'd2, 8'h02}},
  9: '{TR_DONE, '{2'b00, 4'd0, 1'b0, 4'd0, 8'h00}},
  default: '{TR_DONE, '{2'b00, 4'd0, 1'b0, 4'd0, 8'h00}}
};

`endif

//--- common/tag_gw_pkg.sv
package tag_gw_pkg;

  //////////////////////////////////////////////////
  // Field widths

  // Node id of a tag client
  typedef logic [3:0] tag_node_t;

  // Payload length in bits, 1 to 8
  typedef logic [3:0] tag_len_t;

  typedef logic [7:0] tag_payload_t;

  // One enable bit per tag master
  localparam int TAG_NUM_MASTERS = 2;
  typedef logic [TAG_NUM_MASTERS-1:0] tag_masters_t;

  // Trace ROM addressing
  typedef logic [4:0] rom_addr_t;
  localparam int TRACE_ROM_DEPTH = 2 ** $bits(rom_addr_t);

  //////////////////////////////////////////////////
  // Wire format

  // Start bit, node, data_not_reset, len
  localparam int TAG_PKT_HDR_BITS = 10;

  // Longest packet on the data line
  localparam int TAG_WIRE_BITS = TAG_PKT_HDR_BITS + $bits(tag_payload_t);

  typedef logic [TAG_WIRE_BITS-1:0] tag_wire_t;

  // Counts bit positions within one packet
  typedef logic [$clog2(TAG_WIRE_BITS+1)-1:0] tag_bit_cnt_t;

  //////////////////////////////////////////////////
  // Trace entries

  typedef enum logic [1:0] {
    TR_SEND = 2'd0,
    TR_WAIT = 2'd1,
    TR_DONE = 2'd2
  } tag_op_e;

  typedef struct packed {
    tag_masters_t masters;
    tag_node_t    node;
    logic         data_not_reset;
    tag_len_t     len;
    tag_payload_t payload;
  } tag_pkt_s;

  // For TR_WAIT the payload holds the idle cycle count
  typedef struct packed {
    tag_op_e  op;
    tag_pkt_s pkt;
  } trace_entry_s;

endpackage

//--- replay/tag_trace_decode.sv
`timescale 1ns/1ps

module tag_trace_decode
  import tag_gw_pkg::*;
(
  input  logic     bsg_bigblade_pcb,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  logic     busy_i,
  output tag_pkt_s pkt_o,
  output logic     pkt_v_o,
  output logic     done_o
);

  `include "tag_trace_rom.svh"

  typedef enum logic [1:0] {
    FETCH,
    ISSUE,
    WAIT,
    DONE
  } dec_state_e;

  dec_state_e   state_q, state_d;
  rom_addr_t    addr_q, addr_d;
  tag_payload_t wait_q, wait_d;
  tag_pkt_s     pkt_q;
  trace_entry_s entry;

  // ROM read at the current pointer
  assign entry = TRACE_ROM[addr_q];

  //////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    wait_d  = wait_q;
    case (state_q)
      FETCH: begin
        if (en_i) begin
          case (entry.op)
            TR_SEND: begin
              addr_d  = addr_q + 1'b1;
              state_d = ISSUE;
            end
            TR_WAIT: begin
              addr_d = addr_q + 1'b1;
              wait_d = entry.pkt.payload;
              // Zero-cycle wait falls straight through
              if (entry.pkt.payload != '0) begin
                state_d = WAIT;
              end
            end
            TR_DONE: begin
              // Let the last packet drain first
              if (!busy_i) begin
                state_d = DONE;
              end
            end
            default: state_d = DONE;
          endcase
        end
      end
      ISSUE: begin
        if (!busy_i) begin
          state_d = FETCH;
        end
      end
      WAIT: begin
        wait_d = wait_q - 1'b1;
        if (wait_q == tag_payload_t'(1)) begin
          state_d = FETCH;
        end
      end
      DONE: state_d = DONE;
      default: state_d = FETCH;
    endcase
  end

  //////////////////////////////////////////////////
  // Registers

  always_ff @(posedge bsg_bigblade_pcb) begin
    if (!rst_n_i) begin
      state_q <= FETCH;
      addr_q  <= '0;
      wait_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      wait_q  <= wait_d;
    end
  end

  // Packet held until the serializer takes it
  always_ff @(posedge bsg_bigblade_pcb) begin
    if (state_q == FETCH && en_i && entry.op == TR_SEND) begin
      pkt_q <= entry.pkt;
    end
  end

  assign pkt_o   = pkt_q;
  assign pkt_v_o = (state_q == ISSUE) && !busy_i;
  assign done_o  = (state_q == DONE);

endmodule

//--- replay/tag_bit_serializer.sv
`timescale 1ns/1ps

module tag_bit_serializer
  import tag_gw_pkg::*;
(
  input  logic         bsg_bigblade_pcb,
  input  logic         rst_n_i,
  input  tag_pkt_s     pkt_i,
  input  logic         pkt_v_i,
  output logic         busy_o,
  output logic         tag_data_o,
  output tag_masters_t tag_en_o
);

  logic         busy_q;
  tag_bit_cnt_t bit_cnt_q;
  tag_bit_cnt_t last_bit_q;
  tag_wire_t    shift_q;
  tag_masters_t masters_q;
  logic         load;

  assign load = pkt_v_i && !busy_q;

  //////////////////////////////////////////////////
  // Bit counter and busy level

  always_ff @(posedge bsg_bigblade_pcb) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
    end else if (load) begin
      busy_q    <= 1'b1;
      bit_cnt_q <= '0;
    end else if (busy_q) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      // Drop busy once the final bit has been on the line
      if (bit_cnt_q == last_bit_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift register

  // LSB goes out first, so the start bit sits at bit 0
  always_ff @(posedge bsg_bigblade_pcb) begin
    if (load) begin
      shift_q    <= {pkt_i.payload, pkt_i.len, pkt_i.data_not_reset, pkt_i.node, 1'b1};
      masters_q  <= pkt_i.masters;
      last_bit_q <= tag_bit_cnt_t'(TAG_PKT_HDR_BITS - 1) + tag_bit_cnt_t'(pkt_i.len);
    end else if (busy_q) begin
      shift_q <= shift_q >> 1;
    end
  end

  // Line and enables are quiet between packets
  assign tag_data_o = busy_q & shift_q[0];
  assign tag_en_o   = busy_q ? masters_q : '0;
  assign busy_o     = busy_q;

endmodule

//--- logic/tag_client_capture.sv
`timescale 1ns/1ps

module tag_client_capture
  import tag_gw_pkg::*;
#(
  parameter tag_node_t    CLIENT_NODE      = 4'd2,
  parameter tag_payload_t CLIENT_RESET_VAL = 8'h01
) (
  input  logic         bsg_bigblade_pcb,
  input  logic         rst_n_i,
  input  logic         tag_data_i,
  input  logic         tag_en_i,
  output tag_payload_t data_o,
  output logic         output_disable_o
);

  // Header as received, node arrives first
  typedef struct packed {
    tag_len_t  len;
    logic      dnr;
    tag_node_t node;
  } rx_hdr_s;

  typedef enum logic [1:0] {
    IDLE,
    HDR,
    BODY
  } rx_state_e;

  // Header bits that follow the start bit
  localparam tag_bit_cnt_t HDR_LAST = tag_bit_cnt_t'(TAG_PKT_HDR_BITS - 2);
  localparam tag_bit_cnt_t PAY_LAST = tag_bit_cnt_t'($bits(tag_payload_t) - 1);

  rx_state_e    state_q;
  tag_bit_cnt_t cnt_q;
  rx_hdr_s      hdr_q;
  tag_payload_t pay_q, pay_next;
  tag_payload_t data_q;
  logic         rx_bit;
  logic         body_last;

  // Only master 0 reaches this client
  assign rx_bit = tag_data_i & tag_en_i;

  always_comb begin
    pay_next = pay_q;
    pay_next[cnt_q[2:0]] = rx_bit;
  end

  assign body_last = (cnt_q + 1'b1 >= tag_bit_cnt_t'(hdr_q.len)) || (cnt_q == PAY_LAST);

  //////////////////////////////////////////////////
  // Receive FSM and client register

  always_ff @(posedge bsg_bigblade_pcb) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      data_q  <= CLIENT_RESET_VAL;
    end else begin
      case (state_q)
        IDLE: begin
          if (rx_bit) begin
            state_q <= HDR;
            cnt_q   <= '0;
          end
        end
        HDR: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == HDR_LAST) begin
            state_q <= BODY;
            cnt_q   <= '0;
          end
        end
        BODY: begin
          cnt_q <= cnt_q + 1'b1;
          if (body_last) begin
            state_q <= IDLE;
            if (hdr_q.node == CLIENT_NODE) begin
              data_q <= hdr_q.dnr ? pay_next : CLIENT_RESET_VAL;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Header and payload shift paths
  always_ff @(posedge bsg_bigblade_pcb) begin
    if (state_q == HDR) begin
      hdr_q <= {rx_bit, hdr_q[$bits(rx_hdr_s)-1:1]};
    end
    if (state_q == HDR && cnt_q == HDR_LAST) begin
      pay_q <= '0;
    end else if (state_q == BODY) begin
      pay_q <= pay_next;
    end
  end

  assign data_o           = data_q;
  assign output_disable_o = data_q[0];

endmodule

//--- logic/core_clk_downsample.sv
`timescale 1ns/1ps

module core_clk_downsample #(
  parameter int SLOWDOWN_RATIO = 16
) (
  input  logic bsg_bigblade_pcb,
  input  logic rst_n_i,
  input  logic done_i,
  output logic clk_en_o
);

  localparam int CNT_W = (SLOWDOWN_RATIO > 1) ? $clog2(SLOWDOWN_RATIO) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SLOWDOWN_RATIO - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             tick;

  assign tick = (cnt_q == CNT_LAST);

  // Wrap counter, parked at zero once programming is over
  always_ff @(posedge bsg_bigblade_pcb) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (done_i) begin
      cnt_q <= '0;
    end else if (tick) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Full rate after the trace
  assign clk_en_o = done_i | tick;

endmodule

//--- logic/tag_gateway_top.sv
`timescale 1ns/1ps

module tag_gateway_top
  import tag_gw_pkg::*;
#(
  parameter tag_node_t    CLIENT_NODE      = 4'd2,
  parameter tag_payload_t CLIENT_RESET_VAL = 8'h01,
  parameter int           SLOWDOWN_RATIO   = 16
) (
  input  logic         bsg_bigblade_pcb,
  input  logic         rst_n_i,
  input  logic         en_i,
  output logic         tag_data_o,
  output logic         tag_en_o,
  output logic         output_disable_o,
  output tag_payload_t client_data_o,
  output logic         trace_done_o,
  output logic         core_clk_en_o
);

  tag_pkt_s     pkt;
  logic         pkt_v;
  logic         busy;
  tag_masters_t tag_en_lo;

  //////////////////////////////////////////////////
  // Trace replay

  tag_trace_decode u_decode (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .rst_n_i          (rst_n_i),
    .en_i             (en_i),
    .busy_i           (busy),
    .pkt_o            (pkt),
    .pkt_v_o          (pkt_v),
    .done_o           (trace_done_o)
  );

  tag_bit_serializer u_serializer (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .rst_n_i          (rst_n_i),
    .pkt_i            (pkt),
    .pkt_v_i          (pkt_v),
    .busy_o           (busy),
    .tag_data_o       (tag_data_o),
    .tag_en_o         (tag_en_lo)
  );

  // Master 1 leaves the chip, master 0 feeds the local client
  assign tag_en_o = tag_en_lo[1];

  //////////////////////////////////////////////////
  // Client and core clock enable

  tag_client_capture #(
    .CLIENT_NODE      (CLIENT_NODE),
    .CLIENT_RESET_VAL (CLIENT_RESET_VAL)
  ) u_client (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .rst_n_i          (rst_n_i),
    .tag_data_i       (tag_data_o),
    .tag_en_i         (tag_en_lo[0]),
    .data_o           (client_data_o),
    .output_disable_o (output_disable_o)
  );

  core_clk_downsample #(
    .SLOWDOWN_RATIO (SLOWDOWN_RATIO)
  ) u_core_ds (
    .bsg_bigblade_pcb (bsg_bigblade_pcb),
    .rst_n_i          (rst_n_i),
    .done_i           (trace_done_o),
    .clk_en_o         (core_clk_en_o)
  );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset released just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- dv/tag_gateway_tb.sv
`timescale 1ns/1ps

module tag_gateway_tb
  import tag_gw_pkg::*;
;

  localparam tag_node_t    CLIENT_NODE      = 4'd2;
  localparam tag_payload_t CLIENT_RESET_VAL = 8'h01;
  localparam int           SLOWDOWN_RATIO   = 16;
  localparam int           NUM_ROWS         = 10;

  typedef struct {
    int           pause;
    tag_op_e      op;
    logic [1:0]   masters;
    logic [3:0]   node;
    logic         dnr;
    logic [3:0]   len;
    logic [7:0]   payload;
    logic [7:0]   client;
  } row_t;

  logic         clk;
  logic         rst_n;
  logic         en_i;
  logic         tag_data_o;
  logic         tag_en_o;
  logic         output_disable_o;
  tag_payload_t client_data_o;
  logic         trace_done_o;
  logic         core_clk_en_o;

  row_t rows [NUM_ROWS];
  int   m1_seen;
  int   fail_count;

  tb_clock_gen #(.RESET_CYCLES(8)) u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tag_gateway_top #(
    .CLIENT_NODE      (CLIENT_NODE),
    .CLIENT_RESET_VAL (CLIENT_RESET_VAL),
    .SLOWDOWN_RATIO   (SLOWDOWN_RATIO)
  ) UUT (
    .bsg_bigblade_pcb (clk),
    .rst_n_i          (rst_n),
    .en_i             (en_i),
    .tag_data_o       (tag_data_o),
    .tag_en_o         (tag_en_o),
    .output_disable_o (output_disable_o),
    .client_data_o    (client_data_o),
    .trace_done_o     (trace_done_o),
    .core_clk_en_o    (core_clk_en_o)
  );

  //////////////////////////////////////////////////
  // Error reporting

  task automatic report_mismatch(input string name, input int exp, input int act);
    fail_count++;
    $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // Stimulus table

  task automatic set_row(input int r, input int pause, input tag_op_e op,
                         input logic [1:0] masters, input logic [3:0] node, input logic dnr,
                         input logic [3:0] len, input logic [7:0] payload,
                         input logic [7:0] client);
    rows[r] = '{pause, op, masters, node, dnr, len, payload, client};
  endtask

  // Pauses only follow a row whose start is visible on master 1, or reset
  initial begin
    set_row(0, 3, TR_SEND, 2'b11, 4'd2, 1'b1, 4'd1, 8'h00, 8'h00);
    set_row(1, 0, TR_SEND, 2'b10, 4'd5, 1'b1, 4'd8, 8'hA5, 8'h00);
    set_row(2, 4, TR_WAIT, 2'b00, 4'd0, 1'b0, 4'd0, 8'd20, 8'h00);
    set_row(3, 0, TR_SEND, 2'b11, 4'd2, 1'b1, 4'd4, 8'h0B, 8'h0B);
    set_row(4, 2, TR_SEND, 2'b01, 4'd2, 1'b1, 4'd8, 8'h3C, 8'h3C);
    set_row(5, 0, TR_SEND, 2'b11, 4'd7, 1'b1, 4'd6, 8'h2A, 8'h3C);
    set_row(6, 3, TR_WAIT, 2'b00, 4'd0, 1'b0, 4'd0, 8'd5, 8'h3C);
    set_row(7, 0, TR_SEND, 2'b11, 4'd2, 1'b0, 4'd1, 8'h00, CLIENT_RESET_VAL);
    // Pause outlasts the row 7 packet
    set_row(8, 16, TR_SEND, 2'b11, 4'd2, 1'b1, 4'd2, 8'h02, 8'h02);
    set_row(9, 0, TR_DONE, 2'b00, 4'd0, 1'b0, 4'd0, 8'h00, 8'h02);
  end

  function automatic int next_master1_row(input int from);
    for (int r = from; r < NUM_ROWS; r++) begin
      if (rows[r].op == TR_SEND && rows[r].masters[1]) return r;
    end
    return -1;
  endfunction

  function automatic int count_master1_rows();
    int n;
    n = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].op == TR_SEND && rows[r].masters[1]) n++;
    end
    return n;
  endfunction

  //////////////////////////////////////////////////
  // Driver tasks, all at 1 ns after the rising edge

  task automatic hold_enable_low(input int cycles);
    logic prev;
    en_i = 1'b0;
    prev = tag_en_o;
    repeat (cycles) begin
      @(posedge clk);
      #1;
      assert (!(tag_en_o && !prev))
        else report_error("A packet started while en_i was held low");
      prev = tag_en_o;
    end
  endtask

  task automatic wait_master1_start();
    logic prev;
    logic started;
    prev    = tag_en_o;
    started = 1'b0;
    while (!started) begin
      @(posedge clk);
      #1;
      started = tag_en_o && !prev;
      prev    = tag_en_o;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    en_i       = 1'b0;
    m1_seen    = 0;
    fail_count = 0;
    wait (rst_n === 1'b1);
    assert (output_disable_o === 1'b1)
      else report_mismatch("reset output_disable", 1, output_disable_o);
    assert (client_data_o === CLIENT_RESET_VAL)
      else report_mismatch("reset client_data", CLIENT_RESET_VAL, client_data_o);
    assert (tag_en_o === 1'b0) else report_mismatch("reset tag_en", 0, tag_en_o);
    assert (trace_done_o === 1'b0) else report_mismatch("reset trace_done", 0, trace_done_o);

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].pause > 0) begin
        hold_enable_low(rows[r].pause);
      end
      en_i = 1'b1;
      if (rows[r].op == TR_SEND && rows[r].masters[1]) begin
        wait_master1_start();
      end
    end

    while (trace_done_o !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    repeat (20) @(posedge clk);
    #1;
    assert (m1_seen == count_master1_rows())
      else report_mismatch("master-1 packet count", count_master1_rows(), m1_seen);
    assert (client_data_o === rows[NUM_ROWS-1].client)
      else report_mismatch("final client_data", rows[NUM_ROWS-1].client, client_data_o);

    if (fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // Master-1 packet monitor and client checks

  initial begin
    logic        prev;
    logic [17:0] wire_bits;
    int          n;
    int          idx;
    int          cur;
    logic [7:0]  pay;
    prev = 1'b0;
    n    = 0;
    idx  = -1;
    cur  = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      if (tag_en_o && !prev) begin
        idx = next_master1_row(cur);
        assert (idx >= 0) else report_error("Master-1 packet seen with no SEND row left");
        // Client must already reflect the previous row
        if (idx > 0) begin
          assert (client_data_o === rows[idx-1].client)
            else report_mismatch("client before packet", rows[idx-1].client, client_data_o);
        end
        n         = 0;
        wire_bits = '0;
      end
      if (tag_en_o) begin
        if (n < 18) wire_bits[n] = tag_data_o;
        n++;
      end else if (prev) begin
        assert (n == 10 + rows[idx].len)
          else report_mismatch("packet length", 10 + rows[idx].len, n);
        assert (wire_bits[0] === 1'b1) else report_mismatch("start bit", 1, wire_bits[0]);
        assert (wire_bits[4:1] === rows[idx].node)
          else report_mismatch("packet node", rows[idx].node, wire_bits[4:1]);
        assert (wire_bits[5] === rows[idx].dnr)
          else report_mismatch("packet data_not_reset", rows[idx].dnr, wire_bits[5]);
        assert (wire_bits[9:6] === rows[idx].len)
          else report_mismatch("packet len", rows[idx].len, wire_bits[9:6]);
        pay = '0;
        for (int b = 0; b < rows[idx].len; b++) begin
          pay[b] = wire_bits[10+b];
        end
        assert (pay === rows[idx].payload)
          else report_mismatch("packet payload", rows[idx].payload, pay);
        assert (client_data_o === rows[idx].client)
          else report_mismatch("client after packet", rows[idx].client, client_data_o);
        assert (output_disable_o === rows[idx].client[0])
          else report_mismatch("output_disable", rows[idx].client[0], output_disable_o);
        m1_seen++;
        cur = idx + 1;
      end
      prev = tag_en_o;
    end
  end

  //////////////////////////////////////////////////
  // Core clock enable and completion

  initial begin
    int   gap;
    logic seen_pulse;
    logic done_seen;
    gap        = 0;
    seen_pulse = 1'b0;
    done_seen  = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      if (trace_done_o) begin
        if (!done_seen) begin
          assert (m1_seen == count_master1_rows() && !tag_en_o)
            else report_error("trace_done rose before the last packet ended");
        end
        done_seen = 1'b1;
        assert (core_clk_en_o === 1'b1)
          else report_mismatch("core_clk_en after done", 1, core_clk_en_o);
      end else begin
        assert (!done_seen) else report_error("trace_done fell after it was set");
        gap++;
        if (core_clk_en_o) begin
          if (seen_pulse) begin
            assert (gap == SLOWDOWN_RATIO)
              else report_mismatch("core_clk_en spacing", SLOWDOWN_RATIO, gap);
          end
          gap        = 0;
          seen_pulse = 1'b1;
        end
      end
    end
  end

  // Watchdog sized from the table
  initial begin
    int total_pause;
    total_pause = 0;
    #1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_pause += rows[r].pause;
    end
    #((NUM_ROWS * 40 + total_pause + 200) * 10);
    $display("Timeout: the trace did not complete in time");
    $display("** FAIL **");
    $fatal(1);
  end

endmodule

//--- src.f
+incdir+common
common/tag_gw_pkg.sv
replay/tag_trace_decode.sv
replay/tag_bit_serializer.sv
logic/tag_client_capture.sv
logic/core_clk_downsample.sv
logic/tag_gateway_top.sv
dv/tb_clock_gen.sv
dv/tag_gateway_tb.sv

//--- Bender.yml
package:
  name: tag_gateway

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tag_gw_pkg.sv
      - replay/tag_trace_decode.sv
      - replay/tag_bit_serializer.sv
      - logic/tag_client_capture.sv
      - logic/core_clk_downsample.sv
      - logic/tag_gateway_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tag_gateway_tb.sv
